// File: verilog.f
+incdir+.
dma_pkg.sv
dma_ram.sv
dma_regs.sv
dma_engine.sv
dma_top.sv
dma_sva.sv
tb_dma.sv

// File: Makefile
# Verilator build and run for the DMA testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_dma
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Done: no errors

SOURCES := $(filter %.sv,$(shell cat $(FILELIST)))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES) dma_defines.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass message shows up as a line of its own
run: compile
	@out="$$($(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_dma.sv
/*
 * testbench for the DMA block
 *   register, host memory, copy and ignored-start tests
 *   LFSR stimulus, model memories, immediate checks, watchdog
 */

`default_nettype none

`include "dma_defines.svh"

module tb_dma;

	localparam int MAX_CNT = 256;
	localparam int N_COPIES = 3;
	// full memory fills and compares dominate the run length
	localparam int LIMIT = (10 * 4096 + N_COPIES * (MAX_CNT + 64) + 256) * 10 * 2;

	logic           clk;
	logic           rst_n;
	logic           host_we;
	dma_pkg::hadr_t host_wadr;
	dma_pkg::word_t host_wdata;
	dma_pkg::hadr_t host_radr;
	dma_pkg::word_t host_rdata;

	dma_pkg::word_t ram_m [4096];
	dma_pkg::word_t iob_m [4096];
	logic [15:0]    lfsr = 16'd29506;
	int             errors = 0;
	int             checks = 0;
	int             sva_fails;
	int             cyc = 0;

	dma_top i_dut (
		.clk(clk), .rst_n(rst_n), .host_we(host_we), .host_wadr(host_wadr),
		.host_wdata(host_wdata), .host_radr(host_radr), .host_rdata(host_rdata)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// galois lfsr, one step per bit taken
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check_value(input string name, input dma_pkg::word_t exp,
			input dma_pkg::word_t act);
		checks++;
		assert (act === exp)
		else begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic write_word(input dma_pkg::hadr_t adr, input dma_pkg::word_t data);
		host_we = 1'b1;
		host_wadr = adr;
		host_wdata = data;
		@(posedge clk);
		#1;
		host_we = 1'b0;
	endtask

	// data returns one cycle after the address
	task automatic read_word(input dma_pkg::hadr_t adr, output dma_pkg::word_t data);
		host_radr = adr;
		@(posedge clk);
		#1;
		data = host_rdata;
	endtask

	task automatic expect_read(input string name, input dma_pkg::hadr_t adr,
			input dma_pkg::word_t exp);
		dma_pkg::word_t d;
		read_word(adr, d);
		check_value(name, exp, d);
	endtask

	task automatic compare_mem(input string name, input bit iob);
		for (int i = 0; i < 4096; i++)
			expect_read(name, (iob ? `DMA_IOB_BASE : `DMA_RAM_BASE) + 14'(i),
				iob ? iob_m[i] : ram_m[i]);
	endtask

	// program and start a copy, then apply it to the model
	task automatic start_copy(input dma_pkg::dir_e dir, input dma_pkg::madr_t src,
			input dma_pkg::madr_t dst, input int cnt, output int t1);
		dma_pkg::madr_t io;
		dma_pkg::madr_t mem;
		io = (dir == dma_pkg::dir_mem2io) ? dst : src;
		mem = (dir == dma_pkg::dir_mem2io) ? src : dst;
		write_word(`DMA_REG_IOSTR, {2'b00, io, 2'b00});
		write_word(`DMA_REG_MESTR, {2'b00, mem, 2'b00});
		write_word(`DMA_REG_DCNTR, 16'(cnt));
		write_word(`DMA_REG_START, 16'(dir));
		t1 = cyc;
		for (int i = 0; i < cnt; i++) begin
			if (dir == dma_pkg::dir_mem2io)
				iob_m[dst + 12'(i)] = ram_m[src + 12'(i)];
			else
				ram_m[dst + 12'(i)] = iob_m[src + 12'(i)];
		end
	endtask

	// busy up to count+2 cycles after the start write, idle after
	task automatic wait_idle(input string name, input dma_pkg::dir_e dir, input int cnt,
			input int t1);
		dma_pkg::word_t d;
		int k;
		k = 0;
		while (k <= cnt + 1) begin
			k = cyc - t1;
			read_word(`DMA_REG_START, d);
			check_value(name, (k <= cnt + 1) ? 16'(dir) : 16'h0000, d);
		end
	endtask

	initial begin
		dma_pkg::word_t d;
		dma_pkg::madr_t src;
		dma_pkg::madr_t dst;
		int cnt;
		int t1;
		clk = 1'b0;
		rst_n = 1'b0;
		host_we = 1'b0;
		host_wadr = '0;
		host_wdata = '0;
		host_radr = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// registers after reset, masked read-back, unmapped space
		expect_read("status_reset", `DMA_REG_START, 16'h0000);
		d = rand_bits(16);
		write_word(`DMA_REG_IOSTR, d);
		expect_read("iostr_readback", `DMA_REG_IOSTR, d & 16'h3FFC);
		d = rand_bits(16);
		write_word(`DMA_REG_MESTR, d);
		expect_read("mestr_readback", `DMA_REG_MESTR, d & 16'h3FFC);
		d = rand_bits(16);
		write_word(`DMA_REG_DCNTR, d);
		expect_read("dcntr_readback", `DMA_REG_DCNTR, d & 16'h1FFF);
		write_word(14'h2345, 16'hFFFF);
		expect_read("unmapped", 14'h2345, 16'h0000);
		expect_read("unmapped_reg", 14'h3FF4, 16'h0000);

		// fill both memories from the host, then read back
		for (int i = 0; i < 4096; i++) begin
			ram_m[i] = rand_bits(16);
			iob_m[i] = rand_bits(16);
			write_word(`DMA_RAM_BASE + 14'(i), ram_m[i]);
			write_word(`DMA_IOB_BASE + 14'(i), iob_m[i]);
		end
		compare_mem("ram_host", 1'b0);
		compare_mem("iob_host", 1'b1);

		// mem to io, source wraps past 4095
		src = 12'hF80 | 12'(rand_bits(7));
		dst = 12'(rand_bits(12));
		cnt = 129 + int'(rand_bits(7));
		start_copy(dma_pkg::dir_mem2io, src, dst, cnt, t1);
		wait_idle("mem2io_status", dma_pkg::dir_mem2io, cnt, t1);
		compare_mem("mem2io_iob", 1'b1);
		compare_mem("mem2io_ram", 1'b0);

		// io to mem, same wrap on the source side
		src = 12'hF80 | 12'(rand_bits(7));
		dst = 12'(rand_bits(12));
		cnt = 129 + int'(rand_bits(7));
		start_copy(dma_pkg::dir_io2mem, src, dst, cnt, t1);
		wait_idle("io2mem_status", dma_pkg::dir_io2mem, cnt, t1);
		compare_mem("io2mem_ram", 1'b0);
		compare_mem("io2mem_iob", 1'b1);

		// starts that must not launch a copy
		write_word(`DMA_REG_START, 16'h0003);
		expect_read("start_value3", `DMA_REG_START, 16'h0000);
		write_word(`DMA_REG_START, 16'h0000);
		expect_read("start_value0", `DMA_REG_START, 16'h0000);
		write_word(`DMA_REG_DCNTR, 16'h0000);
		write_word(`DMA_REG_START, 16'h0001);
		expect_read("start_count0", `DMA_REG_START, 16'h0000);

		// register and memory traffic while a copy runs
		src = 12'(rand_bits(12));
		cnt = 32 + int'(rand_bits(5));
		start_copy(dma_pkg::dir_mem2io, src, 12'h100, cnt, t1);
		write_word(`DMA_REG_DCNTR, 16'h0005);
		write_word(`DMA_REG_IOSTR, 16'h0800);
		write_word(`DMA_REG_START, 16'h0002);
		write_word(`DMA_RAM_BASE + 14'h0800, ~ram_m[12'h800]);
		write_word(`DMA_IOB_BASE + 14'h0800, ~iob_m[12'h800]);
		expect_read("busy_ram_read", `DMA_RAM_BASE + 14'h0800, 16'h0000);
		expect_read("busy_dcntr", `DMA_REG_DCNTR, 16'h0005);
		wait_idle("busy_status", dma_pkg::dir_mem2io, cnt, t1);
		expect_read("busy_ram_write", `DMA_RAM_BASE + 14'h0800, ram_m[12'h800]);
		compare_mem("busy_iob", 1'b1);

		sva_fails = i_dut.u_engine.u_sva.n_len + i_dut.u_engine.u_sva.n_idle
			+ i_dut.u_engine.u_sva.n_dir;
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// watchdog
	initial begin
		#(LIMIT);
		$display("timeout: the run did not finish within %0d time units", LIMIT);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: dma_sva.sv
/*
 * concurrent checks on the DMA engine, bound into dma_engine
 *   busy length after an accepted start
 *   no DMA writes while idle
 *   DMA write strobes follow the direction
 */

`default_nettype none

`include "dma_defines.svh"

module dma_sva (
	input wire            clk,
	input wire            rst_n,
	input wire            accept,
	input dma_pkg::dir_e  start_dir,
	input dma_pkg::cnt_t  count,
	input dma_pkg::dir_e  busy_dir,
	input wire            ram_we,
	input wire            iob_we,
	input wire            ram_host_we,
	input wire            iob_host_we
);

	logic [`DMA_CNT_BITS:0] left;
	dma_pkg::dir_e          dir_q;
	int                     n_len = 0;
	int                     n_idle = 0;
	int                     n_dir = 0;

	// busy cycles still expected after a start, and its direction
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			left  <= '0;
			dir_q <= dma_pkg::dir_none;
		end else if (accept) begin
			left  <= {1'b0, count} + 2'd2;
			dir_q <= start_dir;
		end else if (left != '0) begin
			left <= left - 1'b1;
		end
	end

	a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
		(left != '0) == (busy_dir != dma_pkg::dir_none))
	else begin
		$error("busy_dir does not end count+3 cycles after the start");
		n_len++;
	end

	// outside the expected transfer window the ports carry host writes only
	a_idle_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		(left == '0) |-> (ram_we == ram_host_we && iob_we == iob_host_we))
	else begin
		$error("memory write from the DMA while idle");
		n_idle++;
	end

	a_write_dir: assert property (@(posedge clk) disable iff (!rst_n)
		(left != '0) |->
			((!ram_we || dir_q == dma_pkg::dir_io2mem) &&
			 (!iob_we || dir_q == dma_pkg::dir_mem2io)))
	else begin
		$error("DMA write strobe does not match the transfer direction");
		n_dir++;
	end

endmodule

bind dma_engine dma_sva u_sva (
	.clk(clk), .rst_n(rst_n), .accept(accept), .start_dir(start_dir), .count(count),
	.busy_dir(busy_dir), .ram_we(ram_we), .iob_we(iob_we),
	.ram_host_we(ram_host_we), .iob_host_we(iob_host_we)
);

`default_nettype wire

// File: dma_top.sv
/*
 * DMA block top level
 *   host register block, transfer engine
 *   data RAM and I/O buffer instances
 */

`default_nettype none

module dma_top (
	input  wire             clk,
	input  wire             rst_n,
	input  wire             host_we,
	input  dma_pkg::hadr_t  host_wadr,
	input  dma_pkg::word_t  host_wdata,
	input  dma_pkg::hadr_t  host_radr,
	output dma_pkg::word_t  host_rdata
);

	// regs to engine
	dma_pkg::dir_e  start_dir;
	dma_pkg::madr_t io_start;
	dma_pkg::madr_t mem_start;
	dma_pkg::cnt_t  count;
	wire            ram_host_we;
	wire            iob_host_we;
	dma_pkg::madr_t host_madr;
	dma_pkg::word_t host_wdata_q;
	dma_pkg::madr_t host_radr_idx;

	// engine to regs
	dma_pkg::dir_e  busy_dir;
	dma_pkg::word_t ram_rdata;
	dma_pkg::word_t iob_rdata;

	// memory ports
	wire            ram_we;
	dma_pkg::madr_t ram_wadr;
	dma_pkg::word_t ram_wdata;
	dma_pkg::madr_t ram_radr;
	dma_pkg::word_t ram_q;
	wire            iob_we;
	dma_pkg::madr_t iob_wadr;
	dma_pkg::word_t iob_wdata;
	dma_pkg::madr_t iob_radr;
	dma_pkg::word_t iob_q;

	dma_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.host_we(host_we), .host_wadr(host_wadr), .host_wdata(host_wdata),
		.host_radr(host_radr), .busy_dir(busy_dir),
		.ram_rdata(ram_rdata), .iob_rdata(iob_rdata), .host_rdata(host_rdata),
		.start_dir(start_dir), .io_start(io_start), .mem_start(mem_start), .count(count),
		.ram_host_we(ram_host_we), .iob_host_we(iob_host_we), .host_madr(host_madr),
		.host_wdata_o(host_wdata_q), .host_radr_idx(host_radr_idx)
	);

	dma_engine u_engine (
		.clk(clk), .rst_n(rst_n),
		.start_dir(start_dir), .io_start(io_start), .mem_start(mem_start), .count(count),
		.ram_host_we(ram_host_we), .iob_host_we(iob_host_we), .host_madr(host_madr),
		.host_wdata(host_wdata_q), .host_radr_idx(host_radr_idx),
		.ram_q(ram_q), .iob_q(iob_q), .busy_dir(busy_dir),
		.ram_we(ram_we), .ram_wadr(ram_wadr), .ram_wdata(ram_wdata), .ram_radr(ram_radr),
		.iob_we(iob_we), .iob_wadr(iob_wadr), .iob_wdata(iob_wdata), .iob_radr(iob_radr),
		.ram_rdata(ram_rdata), .iob_rdata(iob_rdata)
	);

	dma_ram u_data_ram (
		.clk(clk), .we(ram_we), .wadr(ram_wadr), .wdata(ram_wdata),
		.radr(ram_radr), .rdata(ram_q)
	);

	dma_ram u_io_buf (
		.clk(clk), .we(iob_we), .wadr(iob_wadr), .wdata(iob_wdata),
		.radr(iob_radr), .rdata(iob_q)
	);

endmodule

`default_nettype wire

// File: dma_engine.sv
/*
 * DMA transfer engine
 *   start accept, remaining-word counter
 *   source and destination address counters
 *   run / lag pipeline, two words in flight
 *   memory port routing between DMA and host
 */

`default_nettype none

module dma_engine (
	input  wire             clk,
	input  wire             rst_n,
	input  dma_pkg::dir_e   start_dir,
	input  dma_pkg::madr_t  io_start,
	input  dma_pkg::madr_t  mem_start,
	input  dma_pkg::cnt_t   count,
	input  wire             ram_host_we,
	input  wire             iob_host_we,
	input  dma_pkg::madr_t  host_madr,
	input  dma_pkg::word_t  host_wdata,
	input  dma_pkg::madr_t  host_radr_idx,
	input  dma_pkg::word_t  ram_q,
	input  dma_pkg::word_t  iob_q,
	output dma_pkg::dir_e   busy_dir,
	output logic            ram_we,
	output dma_pkg::madr_t  ram_wadr,
	output dma_pkg::word_t  ram_wdata,
	output dma_pkg::madr_t  ram_radr,
	output logic            iob_we,
	output dma_pkg::madr_t  iob_wadr,
	output dma_pkg::word_t  iob_wdata,
	output dma_pkg::madr_t  iob_radr,
	output dma_pkg::word_t  ram_rdata,
	output dma_pkg::word_t  iob_rdata
);

	dma_pkg::cnt_t  rem;
	dma_pkg::dir_e  cur_dir;
	dma_pkg::madr_t src_adr;
	dma_pkg::madr_t dst_adr;
	dma_pkg::word_t wdata_q;
	logic           run;
	logic           run_l1;
	logic           run_l2;
	logic           busy;
	logic           accept;
	logic           to_io;
	logic           to_mem;
	logic           rd_blk_q;

	// run covers the source read cycles, l2 the destination writes
	assign run    = (rem != '0);
	assign busy   = run | run_l1 | run_l2;
	assign accept = (start_dir != dma_pkg::dir_none) & ~busy;

	assign busy_dir = busy ? cur_dir : dma_pkg::dir_none;
	assign to_io    = busy & (cur_dir == dma_pkg::dir_mem2io);
	assign to_mem   = busy & (cur_dir == dma_pkg::dir_io2mem);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rem     <= '0;
			cur_dir <= dma_pkg::dir_none;
		end else if (accept) begin
			rem     <= count;
			cur_dir <= start_dir;
		end else if (run) begin
			rem <= rem - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run_l1   <= 1'b0;
			run_l2   <= 1'b0;
			rd_blk_q <= 1'b0;
		end else begin
			run_l1   <= run;
			run_l2   <= run_l1;
			rd_blk_q <= busy;
		end
	end

	// address counters wrap at the memory depth
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			src_adr <= '0;
			dst_adr <= '0;
		end else if (accept) begin
			src_adr <= (start_dir == dma_pkg::dir_mem2io) ? mem_start : io_start;
			dst_adr <= (start_dir == dma_pkg::dir_mem2io) ? io_start : mem_start;
		end else begin
			if (run)
				src_adr <= src_adr + 1'b1;
			if (run_l2)
				dst_adr <= dst_adr + 1'b1;
		end
	end

	// lag stage between read data and write
	always_ff @(posedge clk) begin
		wdata_q <= (cur_dir == dma_pkg::dir_io2mem) ? iob_q : ram_q;
	end

	// data ram port
	always_comb begin
		ram_we    = ram_host_we;
		ram_wadr  = host_madr;
		ram_wdata = host_wdata;
		ram_radr  = host_radr_idx;
		if (to_mem) begin
			ram_we    = run_l2;
			ram_wadr  = dst_adr;
			ram_wdata = wdata_q;
		end else if (to_io) begin
			ram_we   = 1'b0;
			ram_radr = src_adr;
		end
	end

	// io buffer port
	always_comb begin
		iob_we    = iob_host_we;
		iob_wadr  = host_madr;
		iob_wdata = host_wdata;
		iob_radr  = host_radr_idx;
		if (to_io) begin
			iob_we    = run_l2;
			iob_wadr  = dst_adr;
			iob_wdata = wdata_q;
		end else if (to_mem) begin
			iob_we   = 1'b0;
			iob_radr = src_adr;
		end
	end

	// host reads issued during a transfer return zero
	assign ram_rdata = rd_blk_q ? '0 : ram_q;
	assign iob_rdata = rd_blk_q ? '0 : iob_q;

endmodule

`default_nettype wire

// File: dma_regs.sv
/*
 * DMA host register block
 *   host write decode into setup registers and memory strobes
 *   start decode, one-cycle pulse
 *   registered read select and read data merge
 */

`default_nettype none

`include "dma_defines.svh"

module dma_regs (
	input  wire             clk,
	input  wire             rst_n,
	input  wire             host_we,
	input  dma_pkg::hadr_t  host_wadr,
	input  dma_pkg::word_t  host_wdata,
	input  dma_pkg::hadr_t  host_radr,
	input  dma_pkg::dir_e   busy_dir,
	input  dma_pkg::word_t  ram_rdata,
	input  dma_pkg::word_t  iob_rdata,
	output dma_pkg::word_t  host_rdata,
	output dma_pkg::dir_e   start_dir,
	output dma_pkg::madr_t  io_start,
	output dma_pkg::madr_t  mem_start,
	output dma_pkg::cnt_t   count,
	output logic            ram_host_we,
	output logic            iob_host_we,
	output dma_pkg::madr_t  host_madr,
	output dma_pkg::word_t  host_wdata_o,
	output dma_pkg::madr_t  host_radr_idx
);

	logic           wr_start;
	logic           wr_iostr;
	logic           wr_mestr;
	logic           wr_dcntr;
	logic           start_ok;
	logic [2:0]     rsel;
	logic [2:0]     rsel_q;
	dma_pkg::word_t reg_mux;
	dma_pkg::word_t reg_q;

	// upper address bits select a 4K-word region
	function automatic logic in_region(input dma_pkg::hadr_t adr, input dma_pkg::hadr_t base);
		return (adr >> `DMA_DEPTH_BITS) == (base >> `DMA_DEPTH_BITS);
	endfunction

	// write decode
	assign wr_start = host_we & (host_wadr == `DMA_REG_START);
	assign wr_iostr = host_we & (host_wadr == `DMA_REG_IOSTR);
	assign wr_mestr = host_we & (host_wadr == `DMA_REG_MESTR);
	assign wr_dcntr = host_we & (host_wadr == `DMA_REG_DCNTR);

	assign ram_host_we = host_we & in_region(host_wadr, `DMA_RAM_BASE);
	assign iob_host_we = host_we & in_region(host_wadr, `DMA_IOB_BASE);

	assign host_madr     = host_wadr[`DMA_DEPTH_BITS-1:0];
	assign host_wdata_o  = host_wdata;
	assign host_radr_idx = host_radr[`DMA_DEPTH_BITS-1:0];

	// values 0 and 3 never start; busy is checked in the engine
	assign start_ok  = wr_start & (host_wdata[1] ^ host_wdata[0]) & (count != '0);
	assign start_dir = start_ok ? dma_pkg::dir_e'(host_wdata[1:0]) : dma_pkg::dir_none;

	// setup registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			io_start  <= '0;
			mem_start <= '0;
			count     <= '0;
		end else begin
			if (wr_iostr)
				io_start <= host_wdata[13:2];
			if (wr_mestr)
				mem_start <= host_wdata[13:2];
			if (wr_dcntr)
				count <= host_wdata[`DMA_CNT_BITS-1:0];
		end
	end

	// register read data, unmapped reads give zero
	always_comb begin
		case (host_radr)
			`DMA_REG_START: reg_mux = {14'd0, busy_dir};
			`DMA_REG_IOSTR: reg_mux = {2'b00, io_start, 2'b00};
			`DMA_REG_MESTR: reg_mux = {2'b00, mem_start, 2'b00};
			`DMA_REG_DCNTR: reg_mux = {3'b000, count};
			default:        reg_mux = '0;
		endcase
	end

	// one-hot select: bit 2 io buffer, bit 1 data ram, bit 0 registers
	assign rsel = {in_region(host_radr, `DMA_IOB_BASE),
	               in_region(host_radr, `DMA_RAM_BASE),
	               ~in_region(host_radr, `DMA_IOB_BASE) & ~in_region(host_radr, `DMA_RAM_BASE)};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rsel_q <= '0;
		else
			rsel_q <= rsel;
	end

	// status is sampled at read time, not at return time
	always_ff @(posedge clk) begin
		reg_q <= reg_mux;
	end

	always_comb begin
		if (rsel_q[2])
			host_rdata = iob_rdata;
		else if (rsel_q[1])
			host_rdata = ram_rdata;
		else if (rsel_q[0])
			host_rdata = reg_q;
		else
			host_rdata = '0;
	end

endmodule

`default_nettype wire

// File: dma_ram.sv
/*
 * synchronous word memory
 *   one write port, one registered read port
 *   read during write to the same address gives the old word
 */

`default_nettype none

`include "dma_defines.svh"

module dma_ram (
	input  wire             clk,
	input  wire             we,
	input  dma_pkg::madr_t  wadr,
	input  dma_pkg::word_t  wdata,
	input  dma_pkg::madr_t  radr,
	output dma_pkg::word_t  rdata
);

	localparam int DEPTH = 1 << `DMA_DEPTH_BITS;

	dma_pkg::word_t mem [DEPTH];

	// write port
	always_ff @(posedge clk) begin
		if (we)
			mem[wadr] <= wdata;
	end

	// read port, one cycle latency
	always_ff @(posedge clk) begin
		rdata <= mem[radr];
	end

endmodule

`default_nettype wire

// File: dma_pkg.sv
/*
 * DMA types
 *   word, host address, memory index and count types
 *   transfer direction enum
 */

`default_nettype none

`include "dma_defines.svh"

package dma_pkg;

	typedef logic [`DMA_WORD_BITS-1:0] word_t;
	typedef logic [`DMA_HADR_BITS-1:0] hadr_t;
	typedef logic [`DMA_DEPTH_BITS-1:0] madr_t;
	typedef logic [`DMA_CNT_BITS-1:0] cnt_t;

	// encoding matches the status bits and the start value
	typedef enum logic [1:0] {
		dir_none   = 2'd0,
		dir_mem2io = 2'd1,
		dir_io2mem = 2'd2
	} dir_e;

endpackage

`default_nettype wire

// File: dma_defines.svh
/*
 * shared constants for the DMA block
 *   register word addresses (start, io start, mem start, count)
 *   host region bases for data RAM and I/O buffer
 *   memory depth and address/count widths
 */

`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// host word addresses of the DMA registers
`define DMA_REG_START 14'h3FF0
`define DMA_REG_IOSTR 14'h3FF1
`define DMA_REG_MESTR 14'h3FF2
`define DMA_REG_DCNTR 14'h3FF3

// region bases, word addressed
`define DMA_RAM_BASE 14'h0000
`define DMA_IOB_BASE 14'h1000

// widths
`define DMA_WORD_BITS 16
`define DMA_HADR_BITS 14
`define DMA_DEPTH_BITS 12
`define DMA_CNT_BITS 13

`endif
